//--- compile.f
+incdir+common
+incdir+testbench
common/stack_pkg.sv
common/core_ctrl_if.sv
core/fetch_unit.sv
core/stack_datapath.sv
core/sequencer.sv
logic/stack_core.sv
testbench/tb_stack_core.sv

//--- testbench/tb_tests.svh
task automatic test_push_store();
	logic [14:0] v;
	addr_t a;
	v = random_value();
	a = addr_t'(STORE_BASE + next_random() % 100);
	new_program();
	emit_param(OP_PUSH, v);
	emit_param(OP_PUSH, 15'(a));
	emit_op(OP_STORE);
	expect_store(a, sign_extend(v));
	run_program("test_push_store");
endtask

task automatic test_alu_ops();
	opcode_e ops [12];
	logic [14:0] x;
	logic [14:0] y;
	addr_t a;
	int i;
	// Last three repeat comparisons with equal operands
	ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_EQ, OP_NEQ, OP_GTR, OP_GTE,
		OP_EQ, OP_GTR, OP_GTE};
	new_program();
	for (i = 0; i < 12; i++)
	begin
		x = random_value();
		y = (i >= 9) ? x : random_value();
		a = addr_t'(STORE_BASE + i);
		emit_param(OP_PUSH, x);
		emit_param(OP_PUSH, y);
		emit_op(ops[i]);
		emit_param(OP_PUSH, 15'(a));
		emit_op(OP_STORE);
		expect_store(a, expected_alu(ops[i], sign_extend(y), sign_extend(x)));
	end
	run_program("test_alu_ops");
endtask

task automatic test_dup_pop();
	logic [14:0] v;
	logic [14:0] w;
	v = random_value();
	w = random_value();
	new_program();
	emit_param(OP_PUSH, v);
	emit_op(OP_DUP);
	emit_op(OP_ADD);
	emit_param(OP_PUSH, 15'd140);
	emit_op(OP_STORE);
	expect_store(16'd140, expected_alu(OP_ADD, sign_extend(v), sign_extend(v)));
	run_program("test_dup_pop dup");

	// POP drops w and leaves v on top
	new_program();
	emit_param(OP_PUSH, v);
	emit_param(OP_PUSH, w);
	emit_op(OP_POP);
	emit_param(OP_PUSH, 15'd141);
	emit_op(OP_STORE);
	expect_store(16'd141, sign_extend(v));
	run_program("test_dup_pop pop");
endtask

task automatic test_load();
	logic [14:0] v;
	addr_t b;
	addr_t a;
	v = random_value();
	b = addr_t'(STORE_BASE + next_random() % 50);
	a = addr_t'(STORE_BASE + 50 + next_random() % 50);
	new_program();
	emit_param(OP_PUSH, v);
	emit_param(OP_PUSH, 15'(b));
	emit_op(OP_STORE);
	emit_param(OP_PUSH, 15'(b));
	emit_op(OP_LOAD);
	emit_param(OP_PUSH, 15'(a));
	emit_op(OP_STORE);
	expect_store(b, sign_extend(v));
	expect_store(a, sign_extend(v));
	run_program("test_load");
endtask

task automatic test_branch();
	logic [14:0] cond;
	string test_name;
	int i;
	cond = random_value() | 15'd1;
	for (i = 0; i < 2; i++)
	begin
		new_program();
		emit_param(OP_PUSH, (i == 0) ? 15'd0 : cond);
		// Word 1 jumps to word 5 when the condition is zero
		emit_param(OP_BFALSE, 15'd4);
		emit_param(OP_PUSH, 15'd1);
		emit_param(OP_PUSH, 15'd120);
		emit_op(OP_STORE);
		emit_param(OP_PUSH, 15'd2);
		emit_param(OP_PUSH, 15'd121);
		emit_op(OP_STORE);
		if (i != 0)
			expect_store(16'd120, 20'd1);
		expect_store(16'd121, 20'd2);
		if (i == 0)
			test_name = "test_branch taken";
		else
			test_name = "test_branch not taken";
		run_program(test_name);
	end

	new_program();
	emit_param(OP_GOTO, 15'd4);
	emit_param(OP_PUSH, 15'd5);
	emit_param(OP_PUSH, 15'd122);
	emit_op(OP_STORE);
	emit_param(OP_PUSH, 15'd7);
	emit_param(OP_PUSH, 15'd123);
	emit_op(OP_STORE);
	expect_store(16'd123, 20'd7);
	run_program("test_branch goto");
endtask

task automatic test_slot_packing();
	logic [14:0] v;
	logic [14:0] w;
	word_t sum;
	v = random_value();
	w = random_value();
	sum = expected_alu(OP_ADD, sign_extend(w), sign_extend(v));

	new_program();
	emit_param(OP_PUSH, v);
	emit_param(OP_PUSH, w);
	emit_word(encode_slots(OP_NOP, OP_DUP, OP_POP, OP_ADD));
	emit_param(OP_PUSH, 15'd130);
	emit_op(OP_STORE);
	expect_store(16'd130, sum);
	run_program("test_slot_packing packed");

	new_program();
	emit_param(OP_PUSH, v);
	emit_param(OP_PUSH, w);
	emit_op(OP_NOP);
	emit_op(OP_DUP);
	emit_op(OP_POP);
	emit_op(OP_ADD);
	emit_param(OP_PUSH, 15'd130);
	emit_op(OP_STORE);
	expect_store(16'd130, sum);
	run_program("test_slot_packing spread");
endtask

//--- testbench/tb_stack_core.sv
`include "stack_consts.svh"

module tb_stack_core;

	timeunit 1ns;
	timeprecision 100ps;

	import stack_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT_CYCLES = 200 * NUM_TESTS;
	localparam int STORE_BASE = 100;
	localparam int STORE_LAST = 199;

	logic clk;
	logic arst_n;
	addr_t memory_address;
	word_t mem_read_value;
	word_t mem_write_value;
	logic mem_write_enable;

	word_t mem [0:`MEM_SIZE-1];
	addr_t write_addr_q[$];
	word_t write_data_q[$];

	// Program under construction and the stores it should make
	word_t program_q[$];
	addr_t exp_addr_q[$];
	word_t exp_data_q[$];

	logic [31:0] lcg_state;
	int cycle_count;

	stack_core u_stack_core (
		.clk(clk),
		.arst_n(arst_n),
		.memory_address(memory_address),
		.mem_read_value(mem_read_value),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

	always #10 clk = ~clk;

	// Memory with registered read and a log of every write
	always @(posedge clk)
	begin
		if (mem_write_enable)
		begin
			mem[memory_address] <= mem_write_value;
			write_addr_q.push_back(memory_address);
			write_data_q.push_back(mem_write_value);
		end
		mem_read_value <= mem[memory_address];
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d clock cycles",
				TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Widest parameter that a slot 0 PUSH can carry
	function automatic logic [14:0] random_value();
		logic [31:0] r;
		r = next_random();
		return r[30:16];
	endfunction

	function automatic word_t sign_extend(input logic [14:0] p);
		return {{5{p[14]}}, p};
	endfunction

	function automatic word_t encode_param(input opcode_e op, input logic [14:0] p);
		return {op, p};
	endfunction

	function automatic word_t encode_slots(input opcode_e s0, input opcode_e s1,
		input opcode_e s2, input opcode_e s3);
		return {s0, s1, s2, s3};
	endfunction

	// Result of TOS op NOS with the tag of TOS
	function automatic word_t expected_alu(input opcode_e op, input word_t top,
		input word_t next);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		a = top[15:0];
		b = next[15:0];
		case (op)
			OP_ADD: r = a + b;
			OP_SUB: r = a - b;
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_XOR: r = a ^ b;
			OP_EQ: r = (a == b) ? 16'd1 : 16'd0;
			OP_NEQ: r = (a != b) ? 16'd1 : 16'd0;
			// Operands fit in 15 bits so the 16-bit difference never overflows
			OP_GTR: r = ($signed(a) > $signed(b)) ? 16'd1 : 16'd0;
			OP_GTE: r = ($signed(a) >= $signed(b)) ? 16'd1 : 16'd0;
			default: r = 16'hxxxx;
		endcase
		return {top[19:16], r};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int store_count();
		int n;
		n = 0;
		foreach (write_addr_q[i])
			if (write_addr_q[i] >= STORE_BASE && write_addr_q[i] <= STORE_LAST)
				n++;
		return n;
	endfunction

	task automatic new_program();
		program_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic emit_word(input word_t w);
		program_q.push_back(w);
	endtask

	task automatic emit_param(input opcode_e op, input logic [14:0] p);
		emit_word(encode_param(op, p));
	endtask

	// One opcode per word with NOPs in the remaining slots
	task automatic emit_op(input opcode_e op);
		emit_word(encode_slots(op, OP_NOP, OP_NOP, OP_NOP));
	endtask

	task automatic expect_store(input addr_t a, input word_t d);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endtask

	// Reset, load the program with a closing GOTO 0, run and compare stores
	task automatic run_program(input string name);
		addr_t got_addr[$];
		word_t got_data[$];
		int i;
		@(posedge clk);
		arst_n <= 1'b0;
		@(posedge clk);
		write_addr_q.delete();
		write_data_q.delete();
		for (i = 0; i < `MEM_SIZE; i++)
			mem[i] = word_t'(i) ^ 20'h5A5A5;
		foreach (program_q[j])
			mem[j] = program_q[j];
		mem[program_q.size()] = encode_param(OP_GOTO, 15'd0);
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		while (store_count() < exp_addr_q.size())
			@(negedge clk);
		// Extra cycles catch stray writes after the last expected store
		repeat (20) @(negedge clk);
		foreach (write_addr_q[j])
		begin
			if (write_addr_q[j] >= STORE_BASE && write_addr_q[j] <= STORE_LAST)
			begin
				got_addr.push_back(write_addr_q[j]);
				got_data.push_back(write_data_q[j]);
			end
		end
		check_value({name, " store count"}, exp_addr_q.size(), got_addr.size());
		foreach (exp_addr_q[j])
		begin
			check_value({name, " address"}, exp_addr_q[j], got_addr[j]);
			check_value({name, " data"}, exp_data_q[j], got_data[j]);
		end
	endtask

	`include "tb_tests.svh"

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		mem_read_value = '0;
		lcg_state = 32'd78;
		cycle_count = 0;
		test_push_store();
		test_alu_ops();
		test_dup_pop();
		test_load();
		test_branch();
		test_slot_packing();
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- logic/stack_core.sv
module stack_core (
	input logic clk,
	input logic arst_n,
	output stack_pkg::addr_t memory_address,
	input stack_pkg::word_t mem_read_value,
	output stack_pkg::word_t mem_write_value,
	output logic mem_write_enable
);

	import stack_pkg::*;

	opcode_e opcode;
	word_t param;
	iptr_t instruction_pointer_next;
	word_t tos;
	logic tos_zero;
	logic in_decode;

	core_ctrl_if ctrl ();

	fetch_unit u_fetch_unit (
		.clk(clk),
		.arst_n(arst_n),
		.ctrl(ctrl.fetch),
		.mem_read_value(mem_read_value),
		.tos(tos),
		.in_decode(in_decode),
		.opcode(opcode),
		.param(param),
		.instruction_pointer_next(instruction_pointer_next)
	);

	stack_datapath u_stack_datapath (
		.clk(clk),
		.arst_n(arst_n),
		.ctrl(ctrl.datapath),
		.opcode(opcode),
		.param(param),
		.instruction_pointer_next(instruction_pointer_next),
		.mem_read_value(mem_read_value),
		.tos(tos),
		.tos_zero(tos_zero),
		.memory_address(memory_address),
		.mem_write_value(mem_write_value)
	);

	sequencer u_sequencer (
		.clk(clk),
		.arst_n(arst_n),
		.ctrl(ctrl.sequencer),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.in_decode(in_decode)
	);

	assign mem_write_enable = ctrl.mem_write_enable;

endmodule

//--- core/sequencer.sv
module sequencer (
	input logic clk,
	input logic arst_n,
	core_ctrl_if.sequencer ctrl,
	input stack_pkg::opcode_e opcode,
	input logic tos_zero,
	output logic in_decode
);

	import stack_pkg::*;

	state_e state;
	state_e state_next;
	// BFALSE already moved the pointer, its slot no longer holds it
	logic branch_pending;

	assign in_decode = state == STATE_DECODE;

	always_comb
	begin
		state_next = state;
		ctrl.sp_sel = SP_CURRENT;
		ctrl.tos_sel = TOS_CURRENT;
		ctrl.op0_sel = OP0_TOS;
		ctrl.op1_sel = OP1_MEM_READ;
		ctrl.alu_op = opcode;
		ctrl.ma_sel = MA_IP;
		ctrl.mw_sel = MW_TOS;
		ctrl.ip_sel = IP_CURRENT;
		ctrl.mem_write_enable = 1'b0;

		case (state)
			STATE_IADDR_ISSUE:
			begin
				ctrl.ip_sel = IP_NEXT;
				state_next = STATE_DECODE;
			end

			STATE_DECODE:
			begin
				case (opcode)
					OP_PUSH, OP_DUP:
					begin
						// Spill TOS to SP-1
						ctrl.sp_sel = SP_DECREMENT;
						ctrl.ma_sel = MA_ALU;
						ctrl.op0_sel = OP0_SP;
						ctrl.op1_sel = OP1_ONE;
						ctrl.alu_op = OP_SUB;
						ctrl.mem_write_enable = 1'b1;
						if (opcode == OP_PUSH)
							ctrl.tos_sel = TOS_PARAM;
						state_next = STATE_IADDR_ISSUE;
					end

					OP_POP:
					begin
						ctrl.ma_sel = MA_SP;
						ctrl.sp_sel = SP_INCREMENT;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					OP_LOAD:
					begin
						ctrl.ma_sel = MA_TOS;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					OP_STORE, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
					OP_EQ, OP_NEQ, OP_GTR, OP_GTE:
					begin
						// Fetch NOS first
						ctrl.ma_sel = MA_SP;
						state_next = STATE_GOT_NOS;
					end

					OP_GOTO:
					begin
						ctrl.ip_sel = IP_BRANCH_TARGET;
					end

					OP_BFALSE:
					begin
						if (tos_zero)
							ctrl.ip_sel = IP_BRANCH_TARGET;
						else
							ctrl.ip_sel = IP_NEXT;
						ctrl.ma_sel = MA_SP;
						ctrl.sp_sel = SP_INCREMENT;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					default:
					begin
						ctrl.ip_sel = IP_NEXT;
					end
				endcase
			end

			STATE_GOT_NOS:
			begin
				if (opcode == OP_STORE)
				begin
					// NOS goes to the address in TOS
					ctrl.ma_sel = MA_TOS;
					ctrl.mw_sel = MW_MEM_READ;
					ctrl.mem_write_enable = 1'b1;
					ctrl.sp_sel = SP_INCREMENT;
					state_next = STATE_LOAD_TOS;
				end
				else
				begin
					ctrl.tos_sel = TOS_ALU_RESULT;
					ctrl.sp_sel = SP_INCREMENT;
					ctrl.ip_sel = IP_NEXT;
					state_next = STATE_DECODE;
				end
			end

			STATE_LOAD_TOS:
			begin
				ctrl.ma_sel = MA_SP;
				ctrl.sp_sel = SP_INCREMENT;
				state_next = STATE_PUSH_MEM_RESULT;
			end

			STATE_PUSH_MEM_RESULT:
			begin
				ctrl.tos_sel = TOS_MEMORY_RESULT;
				if (!branch_pending)
					ctrl.ip_sel = IP_NEXT;
				state_next = STATE_DECODE;
			end

			default:
			begin
				state_next = STATE_IADDR_ISSUE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= STATE_IADDR_ISSUE;
			branch_pending <= 1'b0;
		end
		else
		begin
			state <= state_next;
			branch_pending <= in_decode && opcode == OP_BFALSE;
		end
	end

	a_no_write_on_fetch: assert property (@(posedge clk) disable iff (!arst_n)
		state == STATE_IADDR_ISSUE |-> !ctrl.mem_write_enable);

endmodule

//--- core/stack_datapath.sv
`include "stack_consts.svh"

module stack_datapath (
	input logic clk,
	input logic arst_n,
	core_ctrl_if.datapath ctrl,
	input stack_pkg::opcode_e opcode,
	input stack_pkg::word_t param,
	input stack_pkg::iptr_t instruction_pointer_next,
	input stack_pkg::word_t mem_read_value,
	output stack_pkg::word_t tos,
	output logic tos_zero,
	output stack_pkg::addr_t memory_address,
	output stack_pkg::word_t mem_write_value
);

	import stack_pkg::*;

	addr_t stack_pointer;
	addr_t stack_pointer_next;
	word_t tos_next;
	logic [15:0] alu_op0;
	logic [15:0] alu_op1;
	logic [15:0] alu_result;
	logic [15:0] diff;
	logic diff_zero;
	logic diff_negative;

	assign tos_zero = tos[15:0] == 16'd0;

	// Stack pointer mux
	always_comb
	begin
		case (ctrl.sp_sel)
			SP_DECREMENT: stack_pointer_next = stack_pointer - addr_t'(1);
			SP_INCREMENT: stack_pointer_next = stack_pointer + addr_t'(1);
			default: stack_pointer_next = stack_pointer;
		endcase
	end

	// Operand muxes, only the value field enters the ALU
	always_comb
	begin
		case (ctrl.op0_sel)
			OP0_SP: alu_op0 = stack_pointer;
			default: alu_op0 = tos[15:0];
		endcase
		case (ctrl.op1_sel)
			OP1_ONE: alu_op1 = 16'd1;
			default: alu_op1 = mem_read_value[15:0];
		endcase
	end

	assign diff = alu_op0 - alu_op1;
	assign diff_zero = diff == 16'd0;
	assign diff_negative = diff[15];

	always_comb
	begin
		case (ctrl.alu_op)
			OP_ADD: alu_result = alu_op0 + alu_op1;
			OP_SUB: alu_result = diff;
			OP_AND: alu_result = alu_op0 & alu_op1;
			OP_OR: alu_result = alu_op0 | alu_op1;
			OP_XOR: alu_result = alu_op0 ^ alu_op1;
			// Comparisons yield 0 or 1
			OP_EQ: alu_result = {15'd0, diff_zero};
			OP_NEQ: alu_result = {15'd0, !diff_zero};
			OP_GTR: alu_result = {15'd0, !diff_negative && !diff_zero};
			OP_GTE: alu_result = {15'd0, !diff_negative};
			default: alu_result = 16'd0;
		endcase
	end

	// Top of stack mux, ALU results keep the tag
	always_comb
	begin
		case (ctrl.tos_sel)
			TOS_PARAM: tos_next = param;
			TOS_ALU_RESULT: tos_next = {tos[19:16], alu_result};
			TOS_MEMORY_RESULT: tos_next = mem_read_value;
			default: tos_next = tos;
		endcase
	end

	// Memory address and write data
	always_comb
	begin
		case (ctrl.ma_sel)
			MA_SP: memory_address = stack_pointer;
			MA_TOS: memory_address = tos[15:0];
			MA_ALU: memory_address = alu_result;
			default: memory_address = instruction_pointer_next[`IP_SIZE-1:2];
		endcase
		case (ctrl.mw_sel)
			MW_MEM_READ: mem_write_value = mem_read_value;
			default: mem_write_value = tos;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tos <= '0;
			stack_pointer <= `SP_RESET;
		end
		else
		begin
			tos <= tos_next;
			stack_pointer <= stack_pointer_next;
		end
	end

	// Popping past the top of memory means the program underflowed
	a_sp_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.sp_sel == SP_INCREMENT |=> stack_pointer < `MEM_SIZE);

	// Only an immediate push loads the parameter into TOS
	a_param_push: assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.tos_sel == TOS_PARAM |-> opcode == OP_PUSH && ctrl.mem_write_enable);

endmodule

//--- core/fetch_unit.sv
`include "stack_consts.svh"

module fetch_unit (
	input logic clk,
	input logic arst_n,
	core_ctrl_if.fetch ctrl,
	input stack_pkg::word_t mem_read_value,
	input stack_pkg::word_t tos,
	input logic in_decode,
	output stack_pkg::opcode_e opcode,
	output stack_pkg::word_t param,
	output stack_pkg::iptr_t instruction_pointer_next
);

	import stack_pkg::*;

	iptr_t instruction_pointer;
	word_t latched_instruction;
	word_t current_word;
	iptr_t word_base;

	// Memory answers the fetch in DECODE, later states reuse the copy
	assign current_word = in_decode ? mem_read_value : latched_instruction;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			latched_instruction <= '0;
		else if (in_decode)
			latched_instruction <= mem_read_value;
	end

	// Slot alignment
	always_comb
	begin
		case (instruction_pointer[1:0])
			2'd0:
			begin
				opcode = opcode_e'(current_word[19:15]);
				param = {{5{current_word[14]}}, current_word[14:0]};
			end
			2'd1:
			begin
				opcode = opcode_e'(current_word[14:10]);
				param = {{10{current_word[9]}}, current_word[9:0]};
			end
			2'd2:
			begin
				opcode = opcode_e'(current_word[9:5]);
				param = {{15{current_word[4]}}, current_word[4:0]};
			end
			default:
			begin
				// Last slot has no room for a parameter
				opcode = opcode_e'(current_word[4:0]);
				param = '0;
			end
		endcase
	end

	assign word_base = {instruction_pointer[`IP_SIZE-1:2], 2'b00};

	// Next pointer mux
	always_comb
	begin
		case (ctrl.ip_sel)
			IP_NEXT:
			begin
				// A parameter fills the rest of the word
				if (opcode[4:3] == 2'b11)
					instruction_pointer_next = word_base + iptr_t'(4);
				else
					instruction_pointer_next = instruction_pointer + iptr_t'(1);
			end
			IP_BRANCH_TARGET:
				instruction_pointer_next = word_base + {param[15:0], 2'b00};
			default:
				instruction_pointer_next = instruction_pointer;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			instruction_pointer <= `IP_RESET;
		else
			instruction_pointer <= instruction_pointer_next;
	end

	// Branches always land on slot 0
	a_branch_slot0: assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.ip_sel == IP_BRANCH_TARGET |=> instruction_pointer[1:0] == 2'b00);

	// The sequencer only takes BFALSE when the datapath sees a zero TOS
	a_bfalse_zero: assert property (@(posedge clk) disable iff (!arst_n)
		(ctrl.ip_sel == IP_BRANCH_TARGET && opcode == OP_BFALSE) |-> tos[15:0] == 16'd0);

endmodule

//--- common/core_ctrl_if.sv
interface core_ctrl_if;

	import stack_pkg::*;

	// Selects for the stack registers
	sp_sel_e sp_sel;
	tos_sel_e tos_sel;

	// ALU operands and operation
	op0_sel_e op0_sel;
	op1_sel_e op1_sel;
	opcode_e alu_op;

	// Memory port muxes
	ma_sel_e ma_sel;
	mw_sel_e mw_sel;
	logic mem_write_enable;

	ip_sel_e ip_sel;

	modport sequencer (
		output sp_sel, tos_sel, op0_sel, op1_sel, alu_op,
		output ma_sel, mw_sel, ip_sel, mem_write_enable
	);

	modport datapath (
		input sp_sel, tos_sel, op0_sel, op1_sel, alu_op,
		input ma_sel, mw_sel, mem_write_enable
	);

	modport fetch (
		input ip_sel
	);

endinterface

//--- common/stack_pkg.sv
package stack_pkg;

	`include "stack_consts.svh"

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [`ADDR_SIZE-1:0] addr_t;
	typedef logic [`IP_SIZE-1:0] iptr_t;

	// Codes 24 to 31 carry a parameter in the rest of the word
	typedef enum logic [4:0] {
		OP_NOP = 5'd0,
		OP_POP = 5'd3,
		OP_LOAD = 5'd4,
		OP_STORE = 5'd5,
		OP_ADD = 5'd6,
		OP_SUB = 5'd7,
		OP_GTR = 5'd9,
		OP_GTE = 5'd10,
		OP_EQ = 5'd11,
		OP_NEQ = 5'd12,
		OP_DUP = 5'd13,
		OP_AND = 5'd16,
		OP_OR = 5'd17,
		OP_XOR = 5'd18,
		OP_PUSH = 5'd25,
		OP_GOTO = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_e;

	typedef enum logic [2:0] {
		STATE_IADDR_ISSUE,
		STATE_DECODE,
		STATE_GOT_NOS,
		STATE_LOAD_TOS,
		STATE_PUSH_MEM_RESULT
	} state_e;

	typedef enum logic [1:0] {
		SP_CURRENT,
		SP_DECREMENT,
		SP_INCREMENT
	} sp_sel_e;

	typedef enum logic [1:0] {
		TOS_CURRENT,
		TOS_PARAM,
		TOS_ALU_RESULT,
		TOS_MEMORY_RESULT
	} tos_sel_e;

	typedef enum logic {
		OP0_TOS,
		OP0_SP
	} op0_sel_e;

	typedef enum logic {
		OP1_MEM_READ,
		OP1_ONE
	} op1_sel_e;

	typedef enum logic [1:0] {
		MA_IP,
		MA_SP,
		MA_TOS,
		MA_ALU
	} ma_sel_e;

	typedef enum logic {
		MW_TOS,
		MW_MEM_READ
	} mw_sel_e;

	typedef enum logic [1:0] {
		IP_CURRENT,
		IP_NEXT,
		IP_BRANCH_TARGET
	} ip_sel_e;

endpackage

//--- common/stack_consts.svh
`ifndef STACK_CONSTS_SVH
`define STACK_CONSTS_SVH

// Data word is a 4-bit tag above a 16-bit value
`define WORD_SIZE 20

// Memory address and stack pointer width
`define ADDR_SIZE 16

// Word address times four plus a 2-bit slot index
`define IP_SIZE 18

// Number of words in the shared memory
`define MEM_SIZE 8192

// Stack grows down from near the top of memory
`define SP_RESET (`MEM_SIZE - 8)

// First pointer step wraps to word 0, slot 0
`define IP_RESET {`IP_SIZE{1'b1}}

`endif
